// ==== regex_pkg.sv ====
package regex_pkg;

    ////////////////////////////////////////
    // software register interface
    ////////////////////////////////////////
    localparam int reg_width        = 32;

    // command register codes
    localparam logic [reg_width-1:0] cmd_nop                = 32'd0;
    localparam logic [reg_width-1:0] cmd_write              = 32'd1;
    localparam logic [reg_width-1:0] cmd_read               = 32'd2;
    localparam logic [reg_width-1:0] cmd_start              = 32'd3;
    localparam logic [reg_width-1:0] cmd_restart            = 32'd4;
    localparam logic [reg_width-1:0] cmd_read_elapsed_clock = 32'd5;
    localparam logic [reg_width-1:0] cmd_reset              = 32'd6;

    // status register codes
    localparam logic [reg_width-1:0] status_idle     = 32'd0;
    localparam logic [reg_width-1:0] status_running  = 32'd1;
    localparam logic [reg_width-1:0] status_accepted = 32'd2;
    localparam logic [reg_width-1:0] status_rejected = 32'd3;

    ////////////////////////////////////////
    // block RAM geometry
    ////////////////////////////////////////
    localparam int bram_addr_width  = 11;   // read word address
    localparam int bram_write_width = 36;   // one row, two read words
    localparam int bram_read_width  = 18;   // two bytes plus two parity bits
    localparam int bram_we_width    = 4;    // one enable per byte of a row
    localparam int payload_width    = 16;   // read word without parity

    localparam int char_width       = 8;

    ////////////////////////////////////////
    // matcher program format
    ////////////////////////////////////////
    // upper byte opcode, lower byte operand
    localparam logic [char_width-1:0] op_char   = 8'd1;
    localparam logic [char_width-1:0] op_any    = 8'd2;
    localparam logic [char_width-1:0] op_jmp    = 8'd3;
    localparam logic [char_width-1:0] op_accept = 8'd4;

    localparam int pc_width         = 8;    // program sits in words 0..255

endpackage

// ==== parity_bram.sv ====
`timescale 1ns/1ps

module parity_bram import regex_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_master,
    input  logic [bram_addr_width-1:0]  addr,
    input  logic [bram_write_width-1:0] data_in,
    input  logic [bram_we_width-1:0]    we,
    input  logic                        valid,
    output logic [bram_read_width-1:0]  data_out
);

    localparam int rows = 2 ** (bram_addr_width - 1);
    localparam int data_bits = bram_we_width * char_width;  // parity sits above these

    logic [bram_write_width-1:0] mem [rows];
    logic [bram_addr_width-2:0]  row;
    logic [bram_read_width-1:0]  half_row;

    assign row = addr[bram_addr_width-1:1];

    // pick a half row: two parity bits on top, two bytes below
    always_comb
    begin
        if (addr[0])
            half_row = {mem[row][data_bits+3], mem[row][data_bits+2], mem[row][31:16]};
        else
            half_row = {mem[row][data_bits+1], mem[row][data_bits], mem[row][15:0]};
    end

    // byte-wise write, parity bit travels with its byte
    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            for (int i = 0; i < bram_we_width; i++)
            begin
                if (we[i])
                begin
                    mem[row][i*char_width +: char_width] <= data_in[i*char_width +: char_width];
                    mem[row][data_bits+i]                <= data_in[data_bits+i];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_master)
            data_out <= '0;
        else if (valid)
            data_out <= half_row;   // old contents on a same-cycle write
    end

endmodule

// ==== regex_matcher.sv ====
`timescale 1ns/1ps

module regex_matcher import regex_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_master,
    input  logic                       memory_ready,
    input  logic [payload_width-1:0]   memory_data,
    input  logic                       start_ready,
    input  logic [bram_addr_width-1:0] start_cc_pointer,
    output logic [bram_addr_width-1:0] memory_addr,
    output logic                       memory_valid,
    output logic                       start_valid,
    output logic                       finish,
    output logic                       accept
);

    typedef enum logic [2:0] {
        idle,
        fetch_instr,
        wait_instr,
        fetch_char,
        wait_char,
        execute,
        done
    } state_t;

    state_t                     state, state_next;
    logic [pc_width-1:0]        pc, pc_next;
    logic [bram_addr_width-1:0] cc_pointer, cc_pointer_next;
    logic                       accept_reg, accept_next;

    logic [payload_width-1:0]   instr;          // latched instruction word
    logic [char_width-1:0]      current_char;   // latched string character
    logic [char_width-1:0]      opcode;
    logic [char_width-1:0]      operand;
    logic [char_width-1:0]      fetched_opcode;

    assign opcode         = instr[payload_width-1 -: char_width];
    assign operand        = instr[char_width-1:0];
    assign fetched_opcode = memory_data[payload_width-1 -: char_width];

    assign accept = accept_reg;

    ////////////////////////////////////////
    // state and pointers
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            state      <= idle;
            pc         <= '0;
            cc_pointer <= '0;
            accept_reg <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            pc         <= pc_next;
            cc_pointer <= cc_pointer_next;
            accept_reg <= accept_next;
        end
    end

    // capture read data while it is still on the bus
    always_ff @(posedge clk)
    begin
        if (state == wait_instr)
            instr <= memory_data;
        if (state == wait_char)
            current_char <= memory_data[char_width-1:0];
    end

    ////////////////////////////////////////
    // next state and memory requests
    ////////////////////////////////////////
    always_comb
    begin
        state_next      = state;
        pc_next         = pc;
        cc_pointer_next = cc_pointer;
        accept_next     = accept_reg;
        memory_addr     = '0;
        memory_valid    = 1'b0;
        start_valid     = 1'b0;
        finish          = 1'b0;

        case (state)
            idle:
            begin
                start_valid = start_ready;
                if (start_ready)
                begin
                    pc_next         = '0;
                    cc_pointer_next = start_cc_pointer;
                    accept_next     = 1'b0;
                    state_next      = fetch_instr;
                end
            end

            fetch_instr:
            begin
                memory_addr  = {{(bram_addr_width-pc_width){1'b0}}, pc};
                memory_valid = 1'b1;
                if (memory_ready)   // otherwise hold the request
                    state_next = wait_instr;
            end

            wait_instr:
            begin
                // only CHAR and ANY look at the string
                if (fetched_opcode == op_char || fetched_opcode == op_any)
                    state_next = fetch_char;
                else
                    state_next = execute;
            end

            fetch_char:
            begin
                memory_addr  = cc_pointer;
                memory_valid = 1'b1;
                if (memory_ready)
                    state_next = wait_char;
            end

            wait_char:
            begin
                state_next = execute;
            end

            execute:
            begin
                case (opcode)
                    op_char:
                    begin
                        if (current_char == operand)
                        begin
                            pc_next         = pc + 1'b1;
                            cc_pointer_next = cc_pointer + 1'b1;
                            state_next      = fetch_instr;
                        end
                        else
                        begin
                            accept_next = 1'b0;
                            state_next  = done;
                        end
                    end
                    op_any:
                    begin
                        if (current_char != '0)   // terminator ends the string
                        begin
                            pc_next         = pc + 1'b1;
                            cc_pointer_next = cc_pointer + 1'b1;
                            state_next      = fetch_instr;
                        end
                        else
                        begin
                            accept_next = 1'b0;
                            state_next  = done;
                        end
                    end
                    op_jmp:
                    begin
                        pc_next    = operand;
                        state_next = fetch_instr;
                    end
                    op_accept:
                    begin
                        accept_next = 1'b1;
                        state_next  = done;
                    end
                    default:
                    begin
                        accept_next = 1'b0;  // unknown opcode
                        state_next  = done;
                    end
                endcase
            end

            done:
            begin
                finish     = 1'b1;  // one cycle, accept valid alongside
                state_next = idle;
            end

            default:
            begin
                state_next = idle;
            end
        endcase
    end

endmodule

// ==== regex_host.sv ====
`timescale 1ns/1ps

module regex_host import regex_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_master,
    input  logic [reg_width-1:0] data_in,
    input  logic [reg_width-1:0] address,
    input  logic [reg_width-1:0] start_cc_pointer_in,
    input  logic [reg_width-1:0] cmd,
    output logic [reg_width-1:0] status,
    output logic [reg_width-1:0] data_out
);

    logic                        core_reset;
    logic [reg_width-1:0]        status_next;
    logic [reg_width-1:0]        elapsed_cc, elapsed_cc_next;

    // RAM side
    logic [bram_read_width-1:0]  bram_out;
    logic [payload_width-1:0]    bram_payload;
    logic [reg_width-1:0]        bram_word_ext;
    logic [bram_write_width-1:0] bram_in;
    logic [bram_we_width-1:0]    write_parity;
    logic [bram_addr_width-1:0]  bram_addr;
    logic [bram_we_width-1:0]    bram_we;
    logic                        bram_valid;

    // matcher side
    logic [bram_addr_width-1:0]  memory_addr;
    logic                        memory_valid;
    logic                        memory_ready;
    logic                        start_ready;
    logic                        start_valid;
    logic [bram_addr_width-1:0]  start_cc_pointer;
    logic                        finish;
    logic                        accept;

    // soft reset through the command register
    assign core_reset = reset_master || (cmd == cmd_reset);

    assign bram_payload  = bram_out[payload_width-1:0];
    assign bram_word_ext = {{(reg_width-bram_read_width){1'b0}}, bram_out};

    // even parity per byte stacked above the data word
    always_comb
    begin
        for (int i = 0; i < bram_we_width; i++)
            write_parity[i] = ^data_in[i*char_width +: char_width];
    end

    assign bram_in = {write_parity, data_in};

    ////////////////////////////////////////
    // status and cycle counter
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (core_reset)
        begin
            status     <= status_idle;
            elapsed_cc <= '0;
        end
        else
        begin
            status     <= status_next;
            elapsed_cc <= elapsed_cc_next;
        end
    end

    always_comb
    begin
        status_next      = status;
        elapsed_cc_next  = elapsed_cc;
        data_out         = '0;
        bram_addr        = '0;
        bram_we          = '0;
        bram_valid       = 1'b0;
        memory_ready     = 1'b0;
        start_ready      = 1'b0;
        start_cc_pointer = '0;

        case (status)
            status_idle, status_accepted, status_rejected:
            begin
                // software owns the RAM here
                case (cmd)
                    cmd_write:
                    begin
                        bram_addr  = address[bram_addr_width-1:0];  // bit 0 ignored by the RAM
                        bram_we    = '1;
                        bram_valid = 1'b1;
                    end
                    cmd_read:
                    begin
                        bram_addr  = address[bram_addr_width-1:0];
                        bram_valid = 1'b1;
                        data_out   = bram_word_ext;    // valid from the second cycle
                    end
                    cmd_read_elapsed_clock:
                    begin
                        data_out = elapsed_cc;
                    end
                    cmd_start:
                    begin
                        if (status == status_idle)
                        begin
                            start_ready      = 1'b1;
                            start_cc_pointer = start_cc_pointer_in[bram_addr_width-1:0];
                            bram_addr        = memory_addr;
                            bram_valid       = memory_valid;
                            memory_ready     = 1'b1;
                            if (start_valid)
                            begin
                                status_next     = status_running;
                                elapsed_cc_next = '0;
                            end
                        end
                    end
                    cmd_restart:
                    begin
                        status_next = status_idle;
                    end
                    default:
                    begin
                        status_next = status;
                    end
                endcase
            end

            status_running:
            begin
                // matcher drives the RAM for the whole run
                bram_addr    = memory_addr;
                bram_valid   = memory_valid;
                memory_ready = 1'b1;
                if (finish)
                    status_next = accept ? status_accepted : status_rejected;
                if (!(&elapsed_cc))
                    elapsed_cc_next = elapsed_cc + 1'b1;   // saturate at all ones
            end

            default:
            begin
                status_next = status_idle;
            end
        endcase
    end

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////
    parity_bram ram_i (
        .clk          (clk),
        .reset_master (core_reset),
        .addr         (bram_addr),
        .data_in      (bram_in),
        .we           (bram_we),
        .valid        (bram_valid),
        .data_out     (bram_out)
    );

    regex_matcher matcher_i (
        .clk              (clk),
        .reset_master     (core_reset),
        .memory_ready     (memory_ready),
        .memory_data      (bram_payload),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer),
        .memory_addr      (memory_addr),
        .memory_valid     (memory_valid),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept)
    );

endmodule

// ==== tb_regex_host.sv ====
`timescale 1ns/1ps

module tb_regex_host import regex_pkg::*;
();

    localparam int timeout_cycles = 2000;
    localparam int ram_words = 16;                   // round trip area in read words
    localparam logic [reg_width-1:0] data_base = 32'd1024;   // above the program area
    localparam logic [reg_width-1:0] string_base = 32'd512;

    logic                 clk;
    logic                 reset_master;
    logic [reg_width-1:0] data_in;
    logic [reg_width-1:0] address;
    logic [reg_width-1:0] start_cc_pointer_in;
    logic [reg_width-1:0] cmd;
    logic [reg_width-1:0] status;
    logic [reg_width-1:0] data_out;

    logic [31:0] rows_written [ram_words/2];
    int          errors;
    int          tests_failed;
    int          err_mark;

    always #20 clk = ~clk;

    regex_host regex_host_i (
        .clk                 (clk),
        .reset_master        (reset_master),
        .data_in             (data_in),
        .address             (address),
        .start_cc_pointer_in (start_cc_pointer_in),
        .cmd                 (cmd),
        .status              (status),
        .data_out            (data_out)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    // half row plus even parity of each byte
    function automatic logic [17:0] expected_word(input logic [31:0] row, input logic odd);
        logic [15:0] half;
        half = odd ? row[31:16] : row[15:0];
        return {^half[15:8], ^half[7:0], half};
    endfunction

    function automatic logic [15:0] encode(input logic [7:0] op, input logic [7:0] operand);
        return {op, operand};
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else
        begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("error %0t: %s", $time, what);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // register access
    ////////////////////////////////////////
    task automatic write_row(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        cmd     <= cmd_write;
        address <= addr;
        data_in <= data;
        @(posedge clk);     // row written on this edge
        cmd     <= cmd_nop;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] value);
        @(posedge clk);
        cmd     <= cmd_read;
        address <= addr;
        @(posedge clk);     // one cycle of RAM latency
        @(negedge clk);
        value = data_out;
    endtask

    task automatic read_elapsed(output logic [31:0] value);
        @(posedge clk);
        cmd <= cmd_read_elapsed_clock;
        @(negedge clk);     // combinational path
        value = data_out;
    endtask

    // one cycle of a command and back to nop
    task automatic send_command(input logic [31:0] c);
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        cmd <= cmd_nop;
        @(negedge clk);
    endtask

    task automatic start_run(input logic [31:0] pointer);
        int n;
        n = 0;
        @(posedge clk);
        cmd                 <= cmd_start;
        start_cc_pointer_in <= pointer;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (status != status_running && n < timeout_cycles);
        if (status != status_running)
        begin
            $display("timeout: the run did not start within %0d cycles", timeout_cycles);
            errors++;
        end
        @(posedge clk);
        cmd <= cmd_nop;
        @(negedge clk);
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (status == status_running && n < timeout_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if (status == status_running)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_mark)
            $display("test %0d %s: ok", num, name);
        else
        begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial
    begin
        logic [31:0] rd;
        logic [31:0] elapsed_long;
        logic [31:0] elapsed_short;
        logic [7:0]  c1;
        logic [7:0]  c2;
        logic [7:0]  bad;

        clk                 = 1'b0;
        reset_master        = 1'b1;
        data_in             = '0;
        address             = '0;
        start_cc_pointer_in = '0;
        cmd                 = cmd_nop;
        errors              = 0;
        tests_failed        = 0;
        err_mark            = 0;
        void'($urandom(32'h0f6d3994));

        repeat (16) @(posedge clk);
        reset_master <= 1'b0;
        @(negedge clk);
        check_equal(status, status_idle, "status after reset");

        // test 1 random rows read back word by word with parity
        for (int k = 0; k < ram_words/2; k++)
        begin
            rows_written[k] = $urandom;
            write_row(data_base + 32'(2*k), rows_written[k]);
        end
        for (int k = 0; k < ram_words; k++)
        begin
            read_word(data_base + 32'(k), rd);
            check_equal(rd, {14'd0, expected_word(rows_written[k/2], k[0])}, "ram word");
        end
        end_test(1, "ram round trip");

        // test 2 CHAR c1 CHAR c2 ACCEPT on the string c1 c2 0
        c1 = 8'($urandom % 255 + 1);
        c2 = 8'($urandom % 255 + 1);
        write_row(0, {encode(op_char, c2), encode(op_char, c1)});
        write_row(2, {16'h0000, encode(op_accept, 8'h00)});
        write_row(string_base, {8'h00, c2, 8'h00, c1});
        write_row(string_base + 2, 32'h0);
        start_run(string_base);
        wait_finish();
        check_equal(status, status_accepted, "status after matching string");
        read_elapsed(elapsed_long);
        check_true(elapsed_long != 0, "elapsed count is zero after a run");
        end_test(2, "accept");

        // test 3 second character off by one and then ANY on the terminator
        bad = (c2 == 8'hff) ? 8'h01 : c2 + 8'd1;
        write_row(string_base, {8'h00, bad, 8'h00, c1});
        send_command(cmd_restart);
        start_run(string_base);
        wait_finish();
        check_equal(status, status_rejected, "status after mismatch");
        write_row(0, {encode(op_any, 8'h00), encode(op_any, 8'h00)});
        write_row(2, {16'h0000, encode(op_accept, 8'h00)});
        write_row(string_base, {16'h0000, 8'h00, c1});
        send_command(cmd_restart);
        start_run(string_base);
        wait_finish();
        check_equal(status, status_rejected, "status after ANY on terminator");
        end_test(3, "reject");

        // test 4 JMP over a bad word to ANY and ACCEPT
        send_command(cmd_restart);
        check_equal(status, status_idle, "status after restart");
        write_row(0, {16'hee00, encode(op_jmp, 8'd2)});
        write_row(2, {encode(op_accept, 8'h00), encode(op_any, 8'h00)});
        write_row(string_base + 8, {16'h0000, 8'h00, c2});
        start_run(string_base + 8);
        wait_finish();
        check_equal(status, status_accepted, "status after jump program");
        read_elapsed(elapsed_short);
        check_true(elapsed_short != 0 && elapsed_short < elapsed_long,
            "short run does not count fewer cycles than the longer one");
        end_test(4, "restart any jmp");

        // test 5 endless JMP to itself stopped by the soft reset
        write_row(0, {16'h0000, encode(op_jmp, 8'd0)});
        send_command(cmd_restart);
        start_run(0);
        repeat (100) @(negedge clk);
        check_equal(status, status_running, "status of endless program");
        send_command(cmd_reset);
        check_equal(status, status_idle, "status after soft reset");
        read_elapsed(rd);
        check_equal(rd, 32'd0, "elapsed count after soft reset");
        for (int k = 0; k < ram_words; k++)
        begin
            read_word(data_base + 32'(k), rd);
            check_equal(rd, {14'd0, expected_word(rows_written[k/2], k[0])},
                "ram word after soft reset");
        end
        end_test(5, "soft reset");

        $display("tests 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== regex_host.f ====
regex_pkg.sv
parity_bram.sv
regex_matcher.sv
regex_host.sv
tb_regex_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the regex_host testbench with Verilator and run it

top=tb_regex_host
log=sim.log
fail_msg="FAIL: see errors above"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f regex_host.f -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "$fail_msg" "$log"; then
    echo "simulation reported errors, see $log"
    exit 1
fi

echo "simulation finished without errors"
exit 0
